//--- Makefile
SIM = obj_dir/Vtb_spi_master

all: run

$(SIM): all.f $(wildcard *.sv *.svh)
	verilator --binary --timing -Wno-fatal --top-module tb_spi_master -f all.f

run: $(SIM) spi_stimulus.txt
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- all.f
+incdir+.
spi_pkg.sv
spi_fifo.sv
spi_wb_regs.sv
spi_sequencer.sv
spi_master_top.sv
tb_spi_master.sv

//--- spi_cfg.svh
// spi master configuration
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// bus and data widths
`define SPI_DATA_W      32
`define SPI_ADR_W       5

// entries in each of the three FIFOs
`define SPI_FIFO_DEPTH  8

// register offsets
`define SPI_ADR_CTRL    5'h00
`define SPI_ADR_STAT    5'h04
`define SPI_ADR_RDAT    5'h08
`define SPI_ADR_WDAT    5'h0C
`define SPI_ADR_CMD     5'h10

// CTRL layout, divider sits in the top half
`define SPI_SCK_DIV_W   16

// command word layout
`define SPI_CMD_LEN_W     9   // byte count minus one
`define SPI_CMD_HOLD_BIT  9
`define SPI_CMD_MODE_LSB  12  // two mode bits from here

`endif

//--- spi_fifo.sv
// synchronous fifo
`timescale 1ns/10ps
`default_nettype none

`include "spi_cfg.svh"

module spi_fifo #(
   parameter type payload_t = spi_pkg::word_t,
   parameter int  DEPTH     = `SPI_FIFO_DEPTH
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     flush_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     empty_o,
   output logic     full_o
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             do_push, do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full_o  = (cnt_q == CNT_W'(DEPTH));
   assign empty_o = (cnt_q == '0);
   assign do_push = push_i & ~full_o;   // writes to a full fifo are dropped
   assign do_pop  = pop_i & ~empty_o;
   assign data_o  = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (rst_i | flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (do_push & ~do_pop) cnt_q <= cnt_q + 1'b1;
         else if (do_pop & ~do_push) cnt_q <= cnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) mem[wr_ptr_q] <= data_i;
   end

endmodule

`default_nettype wire

//--- spi_master_top.sv
// wishbone spi master
`timescale 1ns/10ps
`default_nettype none

`include "spi_cfg.svh"

module spi_master_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  logic [`SPI_ADR_W-1:0]  wb_adr_i,
   input  logic [`SPI_DATA_W-1:0] wb_dat_i,
   output logic                   wb_ack_o,
   output logic [`SPI_DATA_W-1:0] wb_dat_o,
   input  logic                   spi_miso_i,
   output logic                   spi_mosi_o,
   output logic                   spi_cs_o,
   output logic                   spi_sck_o
);
   import spi_pkg::*;

   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   ctrl_t   ctrl;
   cmd_t    cmd;
   word_t   tx_word, rx_word;
   logic    soft_rst;
   logic    cmd_valid, cmd_pop;
   logic    tx_valid, tx_pop;
   logic    rx_ready, rx_push;

   assign wb_req.cyc = wb_cyc_i;
   assign wb_req.stb = wb_stb_i;
   assign wb_req.we  = wb_we_i;
   assign wb_req.adr = wb_adr_i;
   assign wb_req.dat = wb_dat_i;
   assign wb_ack_o   = wb_rsp.ack;
   assign wb_dat_o   = wb_rsp.dat;

   spi_wb_regs u_regs (
      .clk_i (clk_i), .rst_i (rst_i), .wb_i (wb_req), .wb_o (wb_rsp),
      .ctrl_o (ctrl), .soft_rst_o (soft_rst),
      .cmd_o (cmd), .cmd_valid_o (cmd_valid), .cmd_pop_i (cmd_pop),
      .tx_word_o (tx_word), .tx_valid_o (tx_valid), .tx_pop_i (tx_pop),
      .rx_word_i (rx_word), .rx_push_i (rx_push), .rx_ready_o (rx_ready)
   );

   spi_sequencer u_seq (
      .clk_i (clk_i), .rst_i (rst_i), .soft_rst_i (soft_rst), .ctrl_i (ctrl),
      .cmd_i (cmd), .cmd_valid_i (cmd_valid), .cmd_pop_o (cmd_pop),
      .tx_word_i (tx_word), .tx_valid_i (tx_valid), .tx_pop_o (tx_pop),
      .rx_word_o (rx_word), .rx_push_o (rx_push), .rx_ready_i (rx_ready),
      .spi_miso_i (spi_miso_i), .spi_mosi_o (spi_mosi_o),
      .spi_cs_o (spi_cs_o), .spi_sck_o (spi_sck_o)
   );

endmodule

`default_nettype wire

//--- spi_pkg.sv
// spi master types
`default_nettype none

`include "spi_cfg.svh"

package spi_pkg;

   typedef logic [`SPI_DATA_W-1:0] word_t;

   typedef enum logic [1:0] {
      SPI_MODE_DUMMY     = 2'd0,
      SPI_MODE_READ      = 2'd1,
      SPI_MODE_WRITE     = 2'd2,
      SPI_MODE_DUMMY_ALT = 2'd3   // read+write pattern, clocks only
   } spi_mode_e;

   typedef struct packed {
      logic [`SPI_SCK_DIV_W-1:0]              sck_div;
      logic [`SPI_DATA_W-`SPI_SCK_DIV_W-5:0] rsvd;
      logic                                  cpol;
      logic                                  cpha;
      logic                                  soft_rst;
      logic                                  en;
   } ctrl_t;

   typedef struct packed {
      logic [`SPI_DATA_W-`SPI_CMD_MODE_LSB-3:0]       rsvd_hi;
      spi_mode_e                                      mode;
      logic [`SPI_CMD_MODE_LSB-`SPI_CMD_HOLD_BIT-2:0] rsvd_lo;
      logic                                           cs_hold;
      logic [`SPI_CMD_LEN_W-1:0]                      length;
   } cmd_t;

   typedef struct packed {
      logic cmd_empty;
      logic cmd_full;
      logic rx_empty;
      logic rx_full;
      logic tx_empty;
      logic tx_full;
   } stat_t;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`SPI_ADR_W-1:0] adr;
      word_t                 dat;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- spi_sequencer.sv
// spi transfer engine
`timescale 1ns/10ps
`default_nettype none

`include "spi_cfg.svh"

module spi_sequencer (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           soft_rst_i,
   input  spi_pkg::ctrl_t ctrl_i,
   input  spi_pkg::cmd_t  cmd_i,
   input  logic           cmd_valid_i,
   output logic           cmd_pop_o,
   input  spi_pkg::word_t tx_word_i,
   input  logic           tx_valid_i,
   output logic           tx_pop_o,
   output spi_pkg::word_t rx_word_o,
   output logic           rx_push_o,
   input  logic           rx_ready_i,
   input  logic           spi_miso_i,
   output logic           spi_mosi_o,
   output logic           spi_cs_o,
   output logic           spi_sck_o
);
   import spi_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_WAIT} state_e;

   state_e                   state_q;
   logic [`SPI_SCK_DIV_W-1:0] div_q;
   logic [3:0]               half_q;    // sck edge within the byte
   logic [1:0]               byte_q;    // byte lane within the word
   logic [`SPI_CMD_LEN_W:0]  rem_q;     // bytes left, current one included
   logic                     rx_pend_q;
   logic                     cs_q, sck_q, mosi_q;
   logic [7:0]               rx_byte_q;
   word_t                    rx_q;

   logic       tick, shift_tick, byte_done, start;
   logic       is_wr, is_rd, can_start;
   logic       last_byte, word_end, wait_go, stall;
   logic       drive_edge, sample_edge;
   logic [2:0] drv_bit;
   logic [1:0] drv_byte;
   logic [7:0] byte_full;
   word_t      rx_ins;

   assign tick       = ctrl_i.en & (div_q == '0);
   assign shift_tick = tick & (state_q == ST_SHIFT);
   assign byte_done  = shift_tick & (half_q == 4'd15);

   assign is_wr     = (cmd_i.mode == SPI_MODE_WRITE);
   assign is_rd     = (cmd_i.mode == SPI_MODE_READ);
   assign can_start = cmd_valid_i & (is_wr ? tx_valid_i : (~is_rd | rx_ready_i));
   assign start     = tick & (state_q == ST_IDLE) & can_start;

   assign last_byte = (rem_q == 1);
   assign word_end  = (byte_q == 2'd3) | last_byte;
   assign wait_go   = ~rx_pend_q | rx_ready_i;
   // hold at the word boundary when data or room is missing
   assign stall     = (is_rd & word_end & ~rx_ready_i) | (is_wr & word_end & ~tx_valid_i);

   // cpha 0 drives on trailing edges, cpha 1 on leading ones
   assign drive_edge  = ctrl_i.cpha ^ half_q[0];
   assign sample_edge = ~drive_edge;
   assign drv_bit     = ctrl_i.cpha ? ~half_q[3:1] : ~(half_q[3:1] + 3'd1);
   assign drv_byte    = (~ctrl_i.cpha & (half_q == 4'd15)) ? byte_q + 2'd1 : byte_q;

   assign byte_full = ctrl_i.cpha ? {rx_byte_q[6:0], spi_miso_i} : rx_byte_q;
   assign rx_ins    = (state_q == ST_SHIFT) ?
                      ({{(`SPI_DATA_W - 8){1'b0}}, byte_full} << {byte_q, 3'b000}) : '0;
   assign rx_word_o = rx_q | rx_ins;

   assign cmd_pop_o = tick & (state_q == ST_WAIT) & wait_go & (rem_q == '0);
   assign tx_pop_o  = shift_tick & is_wr & (half_q == 4'd14) & word_end;
   assign rx_push_o = tick & is_rd & rx_ready_i &
                      ((byte_done & word_end) | ((state_q == ST_WAIT) & rx_pend_q));

   always_ff @(posedge clk_i) begin
      if (rst_i | soft_rst_i) begin
         state_q   <= ST_IDLE;
         div_q     <= '0;
         half_q    <= '0;
         byte_q    <= '0;
         rem_q     <= '0;
         rx_pend_q <= 1'b0;
         cs_q      <= 1'b1;
         sck_q     <= 1'b0;
         mosi_q    <= 1'b0;
      end else if (tick) begin
         div_q <= ctrl_i.sck_div;
         case (state_q)
            ST_IDLE: begin
               sck_q <= ctrl_i.cpol;
               if (can_start) begin
                  state_q <= ST_SHIFT;
                  cs_q    <= 1'b0;
                  half_q  <= '0;
                  byte_q  <= '0;
                  rem_q   <= {1'b0, cmd_i.length} + 1'b1;
                  mosi_q  <= is_wr & tx_word_i[7];
               end else begin
                  div_q <= '0;   // keep deciding every cycle
               end
            end
            ST_SHIFT: begin
               sck_q  <= ~sck_q;
               half_q <= half_q + 4'd1;
               if (half_q != 4'd15) begin
                  if (drive_edge) mosi_q <= is_wr & tx_word_i[{drv_byte, drv_bit}];
               end else begin
                  rem_q     <= rem_q - 1'b1;
                  byte_q    <= byte_q + 2'd1;
                  rx_pend_q <= is_rd & word_end & ~rx_ready_i;
                  if (last_byte | stall) state_q <= ST_WAIT;
                  else if (drive_edge) mosi_q <= is_wr & tx_word_i[{drv_byte, drv_bit}];
               end
            end
            ST_WAIT: begin
               if (wait_go) begin
                  rx_pend_q <= 1'b0;
                  if (rem_q == '0) begin
                     state_q <= ST_IDLE;
                     cs_q    <= ~cmd_i.cs_hold;
                     mosi_q  <= 1'b0;
                  end else if (~is_wr | tx_valid_i) begin
                     state_q <= ST_SHIFT;   // resume half a period before the next edge
                     mosi_q  <= is_wr & tx_word_i[{byte_q, 3'd7}];
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end else if (ctrl_i.en) begin
         div_q <= div_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (shift_tick & sample_edge) rx_byte_q <= {rx_byte_q[6:0], spi_miso_i};
      if (start | rx_push_o) rx_q <= '0;
      else if (byte_done) rx_q <= rx_word_o;   // partial word, kept until pushed
   end

   assign spi_cs_o   = cs_q;
   assign spi_sck_o  = sck_q;
   assign spi_mosi_o = mosi_q;

endmodule

`default_nettype wire

//--- spi_stimulus.txt
# op arg1 arg2 in hex: W adr dat, R adr expected, Q first_byte count, E first_byte count
# S wait cmd_empty, B bytes, C clear capture, K sck_edges, H cs, D cycles, F words
R 04 2A
R 00 0
R 08 0
F 9
R 04 29
W 00 2
R 04 2A
# mode 0 divider 0
W 00 1
C
W 0C 13121110
W 10 2003
S
E 10 4
H 1
# mode 1 divider 3 with cs hold
W 00 30005
C
W 0C 23222120
W 10 2201
S
E 20 2
H 0
W 0C 33323130
W 10 2000
S
E 30 1
H 1
W 00 9
B 10
W 00 5
B 5
W 00 3000D
B 7
Q A1 1
W 10 1000
S
R 08 A1
Q 40 3
W 10 1002
S
R 08 424140
W 00 1
Q 50 4
W 10 1003
S
R 08 53525150
Q 60 9
W 10 1008
S
R 08 63626160
R 08 67666564
R 08 68
R 08 0
# dummy, one byte
C
W 10 0
S
K 10
R 04 2A
# transmit underrun
C
W 0C 03020100
W 10 200B
D C8
W 0C 07060504
D C8
W 0C 0B0A0908
S
E 00 C
# soft reset
W 0C 0
W 10 2200
S
H 0
W 00 0
W 0C 1
W 10 2003
R 04 08
W 00 2
R 04 2A
H 1
R 00 0

//--- spi_wb_regs.sv
// wishbone register front end
`timescale 1ns/10ps
`default_nettype none

`include "spi_cfg.svh"

module spi_wb_regs (
   input  logic             clk_i,
   input  logic             rst_i,
   input  spi_pkg::wb_req_t wb_i,
   output spi_pkg::wb_rsp_t wb_o,
   output spi_pkg::ctrl_t   ctrl_o,
   output logic             soft_rst_o,
   output spi_pkg::cmd_t    cmd_o,
   output logic             cmd_valid_o,
   input  logic             cmd_pop_i,
   output spi_pkg::word_t   tx_word_o,
   output logic             tx_valid_o,
   input  logic             tx_pop_i,
   input  spi_pkg::word_t   rx_word_i,
   input  logic             rx_push_i,
   output logic             rx_ready_o
);
   import spi_pkg::*;

   ctrl_t ctrl_q;
   ctrl_t ctrl_wr;
   cmd_t  cmd_wr;
   cmd_t  cmd_head;
   word_t tx_head;
   word_t rx_head;
   word_t rd_data;
   word_t dat_q;
   stat_t stat;
   logic  ack_q;
   logic  acc, wr_acc, rd_acc;
   logic  cmd_push, tx_push, rx_pop;
   logic  cmd_empty, cmd_full;
   logic  tx_empty, tx_full;
   logic  rx_empty, rx_full;

   // new access only while ack is low
   assign acc    = wb_i.cyc & wb_i.stb & ~ack_q;
   assign wr_acc = acc & wb_i.we;
   assign rd_acc = acc & ~wb_i.we;

   assign cmd_push = wr_acc & (wb_i.adr == `SPI_ADR_CMD);
   assign tx_push  = wr_acc & (wb_i.adr == `SPI_ADR_WDAT);
   assign rx_pop   = rd_acc & (wb_i.adr == `SPI_ADR_RDAT) & ~rx_empty;

   // reserved fields always read back as zero
   always_comb begin
      ctrl_wr         = ctrl_t'(wb_i.dat);
      ctrl_wr.rsvd    = '0;
      cmd_wr          = cmd_t'(wb_i.dat);
      cmd_wr.rsvd_hi  = '0;
      cmd_wr.rsvd_lo  = '0;
   end

   assign stat.cmd_empty = cmd_empty;
   assign stat.cmd_full  = cmd_full;
   assign stat.rx_empty  = rx_empty;
   assign stat.rx_full   = rx_full;
   assign stat.tx_empty  = tx_empty;
   assign stat.tx_full   = tx_full;

   always_comb begin
      case (wb_i.adr)
         `SPI_ADR_CTRL: rd_data = ctrl_q;
         `SPI_ADR_STAT: rd_data = {{(`SPI_DATA_W - $bits(stat_t)){1'b0}}, stat};
         `SPI_ADR_RDAT: rd_data = rx_empty ? '0 : rx_head;
         `SPI_ADR_CMD:  rd_data = cmd_empty ? '0 : cmd_head;
         default:       rd_data = '0;
      endcase
   end

   // soft reset bit clears itself along with the rest of CTRL
   always_ff @(posedge clk_i) begin
      if (rst_i | ctrl_q.soft_rst) ctrl_q <= '0;
      else if (wr_acc & (wb_i.adr == `SPI_ADR_CTRL)) ctrl_q <= ctrl_wr;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) ack_q <= 1'b0;
      else ack_q <= acc;   // single cycle, one clock after the request
   end

   always_ff @(posedge clk_i) begin
      if (acc) dat_q <= rd_data;
   end

   spi_fifo #(.payload_t(cmd_t)) u_cmd_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (soft_rst_o),
      .push_i  (cmd_push),
      .data_i  (cmd_wr),
      .pop_i   (cmd_pop_i),
      .data_o  (cmd_head),
      .empty_o (cmd_empty),
      .full_o  (cmd_full)
   );

   spi_fifo #(.payload_t(word_t)) u_tx_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (soft_rst_o),
      .push_i  (tx_push),
      .data_i  (wb_i.dat),
      .pop_i   (tx_pop_i),
      .data_o  (tx_head),
      .empty_o (tx_empty),
      .full_o  (tx_full)
   );

   spi_fifo #(.payload_t(word_t)) u_rx_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (soft_rst_o),
      .push_i  (rx_push_i),
      .data_i  (rx_word_i),
      .pop_i   (rx_pop),
      .data_o  (rx_head),
      .empty_o (rx_empty),
      .full_o  (rx_full)
   );

   assign wb_o.ack    = ack_q;
   assign wb_o.dat    = dat_q;
   assign ctrl_o      = ctrl_q;
   assign soft_rst_o  = ctrl_q.soft_rst;
   assign cmd_o       = cmd_head;
   assign cmd_valid_o = ~cmd_empty;
   assign tx_word_o   = tx_head;
   assign tx_valid_o  = ~tx_empty;
   assign rx_ready_o  = ~rx_full;

endmodule

`default_nettype wire

//--- tb_spi_master.sv
// spi master testbench
`timescale 1ns/10ps
`default_nettype none

`include "spi_cfg.svh"

module tb_spi_master;
   import spi_pkg::*;

   logic        clk_i;
   logic        rst_i;
   logic        wb_cyc_i, wb_stb_i, wb_we_i;
   logic [4:0]  wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        wb_ack_o;
   logic [31:0] wb_dat_o;
   logic        spi_miso_i;
   logic        spi_mosi_o, spi_cs_o, spi_sck_o;

   // slave model state
   logic        cpol_s, cpha_s;
   logic [7:0]  miso_sh, mosi_sh;
   logic        miso_out;
   int          bit_cnt;
   int          edge_cnt;
   logic [7:0]  reply_q[$];
   logic [7:0]  cap_q[$];

   logic [15:0] lfsr;
   int          err_cnt;
   int          cycles;
   int          limit;

   spi_master_top dut0 (
      .clk_i (clk_i), .rst_i (rst_i),
      .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
      .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
      .wb_ack_o (wb_ack_o), .wb_dat_o (wb_dat_o),
      .spi_miso_i (spi_miso_i), .spi_mosi_o (spi_mosi_o),
      .spi_cs_o (spi_cs_o), .spi_sck_o (spi_sck_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic fail_run(input string why);
      err_cnt++;
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      if (got !== exp) begin
         err_cnt++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   always @(posedge clk_i) begin
      cycles++;
      if (limit > 0 && cycles > limit) fail_run("timeout, run took too many cycles");
   end

   // galois lfsr stepped once per bit
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic load_reply();
      if (reply_q.size() > 0) miso_sh = reply_q.pop_front();
      else miso_sh = 8'h00;
   endtask

   // miso reaches the DUT 2 ns after the clock edge
   always @(posedge clk_i) begin
      #2 spi_miso_i = miso_out;
   end

   always @(negedge spi_cs_o) begin
      bit_cnt = 0;
      if (!cpha_s) begin   // first bit must be out before the leading edge
         load_reply();
         miso_out = miso_sh[7];
      end
   end

   always @(spi_sck_o) begin
      if (spi_cs_o === 1'b0) begin
         edge_cnt++;
         if ((spi_sck_o != cpol_s) ^ cpha_s) begin   // sample edge
            mosi_sh = {mosi_sh[6:0], spi_mosi_o};
            bit_cnt++;
            if (bit_cnt == 8) begin
               cap_q.push_back(mosi_sh);
               bit_cnt = 0;
            end
         end else begin
            if (bit_cnt == 0) load_reply();
            else miso_sh = miso_sh << 1;
            miso_out = miso_sh[7];
         end
      end
   end

   task automatic bus_write(input logic [4:0] adr, input logic [31:0] dat);
      @(posedge clk_i);
      #2;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = adr;
      wb_dat_i = dat;
      do begin
         @(posedge clk_i);
         #1;
      end while (!wb_ack_o);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      if (adr == `SPI_ADR_CTRL) begin
         cpol_s = dat[1] ? 1'b0 : dat[3];   // soft reset clears CTRL
         cpha_s = dat[1] ? 1'b0 : dat[2];
      end
   endtask

   task automatic bus_read(input logic [4:0] adr, output logic [31:0] dat);
      @(posedge clk_i);
      #2;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b0;
      wb_adr_i = adr;
      do begin
         @(posedge clk_i);
         #1;
      end while (!wb_ack_o);
      dat = wb_dat_o;
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic wait_cmd_done();
      logic [31:0] st;
      do bus_read(`SPI_ADR_STAT, st);
      while (!st[5]);
   endtask

   task automatic expect_byte(input logic [7:0] exp);
      if (cap_q.size() == 0) fail_run("slave captured fewer bytes than expected");
      else check_value(cap_q.pop_front(), exp, "slave captured byte");
   endtask

   // random write of n bytes checked at the slave
   task automatic run_burst(input int n);
      logic [7:0]  bytes[$];
      logic [7:0]  b;
      logic [31:0] w;
      w = '0;
      cap_q.delete();
      for (int i = 0; i < n; i++) begin
         for (int k = 0; k < 8; k++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
         end
         bytes.push_back(b);
         w[8*(i%4) +: 8] = b;   // lsb first within the word
         if (i % 4 == 3 || i == n - 1) begin
            bus_write(`SPI_ADR_WDAT, w);
            w = '0;
         end
      end
      bus_write(`SPI_ADR_CMD, 32'h2000 | (n - 1));
      wait_cmd_done();
      foreach (bytes[i]) expect_byte(bytes[i]);
   endtask

   task automatic do_line(input string line);
      byte         op;
      logic [31:0] a, b, d;
      int          n, cnt;
      a = '0;
      b = '0;
      op = line.getc(0);
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
      cnt = (n < 2) ? 1 : int'(b);
      case (op)
         "W": bus_write(a[4:0], b);
         "R": begin
            bus_read(a[4:0], d);
            check_value(d, b, $sformatf("read of register %h", a[4:0]));
         end
         "Q": for (int i = 0; i < cnt; i++) reply_q.push_back(a[7:0] + 8'(i));
         "E": for (int i = 0; i < cnt; i++) expect_byte(a[7:0] + 8'(i));
         "S": wait_cmd_done();
         "B": run_burst(int'(a));
         "C": begin
            cap_q.delete();
            edge_cnt = 0;
         end
         "K": check_value(edge_cnt, a, "sck edge count");
         "H": check_value({31'd0, spi_cs_o}, a, "chip select level");
         "D": repeat (int'(a)) @(posedge clk_i);
         "F": for (int i = 0; i < int'(a); i++) bus_write(`SPI_ADR_WDAT, {4{8'(i + 1)}});
         default: fail_run($sformatf("unknown opcode in stimulus: %s", line));
      endcase
   endtask

   function automatic bit is_op(input string line);
      is_op = (line.len() > 0) && (line.getc(0) != "#") &&
              (line.getc(0) != "\n") && (line.getc(0) != " ");
   endfunction

   initial begin
      int    fd;
      int    n_ops;
      string line;
      wb_cyc_i   = 1'b0;
      wb_stb_i   = 1'b0;
      wb_we_i    = 1'b0;
      wb_adr_i   = '0;
      wb_dat_i   = '0;
      spi_miso_i = 1'b0;
      miso_out   = 1'b0;
      rst_i      = 1'b1;
      cpol_s     = 1'b0;
      cpha_s     = 1'b0;
      miso_sh    = '0;
      mosi_sh    = '0;
      bit_cnt    = 0;
      edge_cnt   = 0;
      lfsr       = 16'(59170);
      err_cnt    = 0;
      cycles     = 0;
      limit      = 0;
      n_ops      = 0;

      // first pass sets the cycle budget
      fd = $fopen("spi_stimulus.txt", "r");
      if (fd == 0) fail_run("cannot open spi_stimulus.txt");
      while ($fgets(line, fd) > 0) if (is_op(line)) n_ops++;
      $fclose(fd);
      limit = n_ops * 600;

      repeat (10) @(posedge clk_i);
      #2 rst_i = 1'b0;

      fd = $fopen("spi_stimulus.txt", "r");
      if (fd == 0) fail_run("cannot reopen spi_stimulus.txt");
      while ($fgets(line, fd) > 0) if (is_op(line)) do_line(line);
      $fclose(fd);

      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire
